// File: design/walk_sound_pkg.sv
/*
 * Walk sound package: sequencer states, the voice control bundle and the
 * timing and amplitude constants shared by the walk footstep voice.
 */
`default_nettype none

package walk_sound_pkg;

    //////////////////////////////////////////////////
    // sample path widths and amplitudes
    //////////////////////////////////////////////////

    localparam int SAMPLE_W     = 16;
    localparam int ENV_W        = 8;
    localparam int PITCH_W      = 10;
    localparam int TIMER_W      = 8;

    localparam int ENV_MAX        = 255;
    localparam int ENV_STEP       = 4;
    localparam int ENV_DECAY_STEP = 2;

    // peak of square times envelope is 32 * 255 = 8160
    localparam int SQUARE_AMP   = 32;

    // one-pole coefficient is 2^-FILTER_SHIFT
    localparam int FILTER_SHIFT = 3;
    localparam int FILTER_SNAP  = 1 << FILTER_SHIFT;

    //////////////////////////////////////////////////
    // phase timing in audio samples
    //////////////////////////////////////////////////

    localparam int ATTACK_SAMPLES  = 64;
    localparam int DECAY_SAMPLES   = 128;

    localparam int PITCH_START     = 6;
    localparam int PITCH_SWEEP_DIV = 8;
    localparam int SWEEP_W         = $clog2(PITCH_SWEEP_DIV);

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_ATTACK,
        WALK_HOLD,
        WALK_DECAY
    } walk_state_t;

    // control bundle from the sequencer to the oscillator and the VCA
    typedef struct packed {
        logic [ENV_W-1:0]   env_level;
        logic [PITCH_W-1:0] pitch_period;
        logic               voice_on;
    } voice_ctrl_t;

endpackage

`default_nettype wire

// File: design/walk_sequencer.sv
/*
 * Walk sequencer: FSM that runs attack, hold and decay on the audio strobe,
 * and produces the envelope level and the sweeping pitch period.
 */
`default_nettype none

module walk_sequencer import walk_sound_pkg::*; (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                audio_clk_en,
    input  wire logic                walk_en,
    input  wire logic                phase_done,
    output logic                     timer_load,
    output logic [TIMER_W-1:0]       timer_length,
    output voice_ctrl_t              voice_ctrl
);

    walk_state_t        state_q;
    walk_state_t        state_d;
    logic [ENV_W-1:0]   env_q;
    logic [ENV_W:0]     env_up;
    logic [PITCH_W-1:0] pitch_q;
    logic [SWEEP_W-1:0] sweep_q;
    logic               enter_attack;
    logic               enter_decay;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            WALK_IDLE:   if (walk_en) state_d = WALK_ATTACK;
            WALK_ATTACK: if (phase_done) state_d = WALK_HOLD;
            WALK_HOLD:   if (!walk_en) state_d = WALK_DECAY;
            WALK_DECAY: begin
                // a new step during the decay restarts the attack from here
                if (walk_en) begin
                    state_d = WALK_ATTACK;
                end else if (phase_done) begin
                    state_d = WALK_IDLE;
                end
            end
            default:     state_d = WALK_IDLE;
        endcase
    end

    assign enter_attack = (state_d == WALK_ATTACK) && (state_q != WALK_ATTACK);
    assign enter_decay  = (state_d == WALK_DECAY) && (state_q != WALK_DECAY);

    // the timer is armed on the very strobe that enters a timed phase
    assign timer_load   = audio_clk_en && (enter_attack || enter_decay);
    assign timer_length = enter_decay ? TIMER_W'(DECAY_SAMPLES) : TIMER_W'(ATTACK_SAMPLES);

    assign env_up = {1'b0, env_q} + (ENV_W + 1)'(ENV_STEP);

    //////////////////////////////////////////////////
    // state, envelope and pitch registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= WALK_IDLE;
            env_q   <= '0;
            pitch_q <= PITCH_W'(PITCH_START);
            sweep_q <= '0;
        end else if (audio_clk_en) begin
            state_q <= state_d;
            case (state_q)
                WALK_IDLE: env_q <= '0;
                WALK_ATTACK: begin
                    if (env_up > (ENV_W + 1)'(ENV_MAX)) begin
                        env_q <= ENV_W'(ENV_MAX);
                    end else begin
                        env_q <= env_up[ENV_W-1:0];
                    end
                end
                WALK_DECAY: begin
                    if (env_q > ENV_W'(ENV_DECAY_STEP)) begin
                        env_q <= env_q - ENV_W'(ENV_DECAY_STEP);
                    end else begin
                        env_q <= '0;
                    end
                    // pitch sinks one sample of half-period every sweep interval
                    sweep_q <= sweep_q + 1'b1;
                    if (sweep_q == SWEEP_W'(PITCH_SWEEP_DIV - 1)) begin
                        pitch_q <= pitch_q + 1'b1;
                    end
                end
                default: ;
            endcase
            if (enter_attack) begin
                pitch_q <= PITCH_W'(PITCH_START);
            end
            if (enter_decay) begin
                sweep_q <= '0;
            end
        end
    end

    assign voice_ctrl.env_level    = env_q;
    assign voice_ctrl.pitch_period = pitch_q;
    assign voice_ctrl.voice_on     = (state_q != WALK_IDLE);

endmodule

`default_nettype wire

// File: design/walk_phase_timer.sv
/*
 * Walk phase timer: counts audio samples down after a load and pulses
 * phase_done for one strobe when the phase length has run out.
 */
`default_nettype none

module walk_phase_timer import walk_sound_pkg::*; (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               audio_clk_en,
    input  wire logic               timer_load,
    input  wire logic [TIMER_W-1:0] timer_length,
    output logic                    phase_done
);

    logic [TIMER_W-1:0] count_q;
    logic               armed_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q    <= '0;
            armed_q    <= 1'b0;
            phase_done <= 1'b0;
        end else if (audio_clk_en) begin
            // the done flag lives for exactly one sample period
            phase_done <= 1'b0;
            if (timer_load) begin
                count_q <= timer_length;
                armed_q <= 1'b1;
            end else if (armed_q) begin
                count_q <= count_q - 1'b1;
                if (count_q == TIMER_W'(1)) begin
                    armed_q    <= 1'b0;
                    phase_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/walk_oscillator.sv
/*
 * Walk oscillator: square wave of +/- SQUARE_AMP whose half-period in
 * samples follows the sequencer's pitch period.
 */
`default_nettype none

module walk_oscillator import walk_sound_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  audio_clk_en,
    input  wire voice_ctrl_t           voice_ctrl,
    output logic signed [SAMPLE_W-1:0] square
);

    logic [PITCH_W-1:0] half_count_q;
    logic               polarity_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            half_count_q <= '0;
            polarity_q   <= 1'b1;
        end else if (audio_clk_en) begin
            if (!voice_ctrl.voice_on) begin
                // parked on the positive half so each step starts there
                half_count_q <= '0;
                polarity_q   <= 1'b1;
            end else if (half_count_q >= voice_ctrl.pitch_period - 1'b1) begin
                // >= covers the pitch dropping back to its start value mid-cycle
                half_count_q <= '0;
                polarity_q   <= ~polarity_q;
            end else begin
                half_count_q <= half_count_q + 1'b1;
            end
        end
    end

    assign square = polarity_q ? SAMPLE_W'(SQUARE_AMP) : -SAMPLE_W'(SQUARE_AMP);

endmodule

`default_nettype wire

// File: design/walk_vca_filter.sv
/*
 * Walk VCA and output filter: scales the square wave by the envelope and
 * smooths it with a one-pole low-pass, standing in for the analog stage.
 */
`default_nettype none

module walk_vca_filter import walk_sound_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  audio_clk_en,
    input  wire logic signed [SAMPLE_W-1:0] square,
    input  wire voice_ctrl_t           voice_ctrl,
    output logic signed [SAMPLE_W-1:0] out
);

    logic signed [SAMPLE_W-1:0] env_s;
    logic signed [SAMPLE_W-1:0] product_q;
    logic signed [SAMPLE_W-1:0] state_q;
    logic signed [SAMPLE_W-1:0] diff;
    logic signed [SAMPLE_W-1:0] step;
    logic                       near_zero;

    // envelope is unsigned, widen it with zeros before the signed multiply
    assign env_s = $signed({{(SAMPLE_W - ENV_W){1'b0}}, voice_ctrl.env_level});

    //////////////////////////////////////////////////
    // one-pole low-pass toward the scaled square
    //////////////////////////////////////////////////

    // both ends stay within +/-8160, so the difference fits in SAMPLE_W
    assign diff = product_q - state_q;
    assign step = diff >>> FILTER_SHIFT;

    // the arithmetic shift rounds toward minus infinity and would leave
    // a small negative residue sitting above a zero target
    assign near_zero = (product_q == '0)
                    && (state_q > -SAMPLE_W'(FILTER_SNAP))
                    && (state_q < SAMPLE_W'(FILTER_SNAP));

    always_ff @(posedge clk) begin
        if (reset) begin
            product_q <= '0;
            state_q   <= '0;
        end else if (audio_clk_en) begin
            product_q <= square * env_s;
            if (near_zero) begin
                state_q <= '0;
            end else begin
                state_q <= state_q + step;
            end
        end
    end

    assign out = state_q;

endmodule

`default_nettype wire

// File: design/dk_walk.sv
/*
 * Walk footstep voice: sequencer, phase timer, square oscillator and
 * VCA filter, stepping one audio sample per audio_clk_en strobe.
 */
`default_nettype none

module dk_walk import walk_sound_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  audio_clk_en,
    input  wire logic                  walk_en,
    output logic signed [SAMPLE_W-1:0] out
);

    voice_ctrl_t                voice_ctrl;
    logic                       timer_load;
    logic [TIMER_W-1:0]         timer_length;
    logic                       phase_done;
    logic signed [SAMPLE_W-1:0] square;

    walk_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en),
        .walk_en      (walk_en),
        .phase_done   (phase_done),
        .timer_load   (timer_load),
        .timer_length (timer_length),
        .voice_ctrl   (voice_ctrl)
    );

    walk_phase_timer u_phase_timer (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en),
        .timer_load   (timer_load),
        .timer_length (timer_length),
        .phase_done   (phase_done)
    );

    walk_oscillator u_oscillator (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en),
        .voice_ctrl   (voice_ctrl),
        .square       (square)
    );

    walk_vca_filter u_vca_filter (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en),
        .square       (square),
        .voice_ctrl   (voice_ctrl),
        .out          (out)
    );

endmodule

`default_nettype wire

// File: testbench/tb_dk_walk.sv
/*
 * Testbench for the walk footstep voice with short steps, a retrigger, random
 * steps and a silent tail, checked by concurrent assertions on out.
 */
`default_nettype none

module tb_dk_walk import walk_sound_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SAMPLE_DIV   = 12;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_STEPS   = 6;
    localparam int TAIL_SAMPLES = 400;
    localparam int PEAK         = SQUARE_AMP * ENV_MAX;
    localparam int HOLD_MIN     = ATTACK_SAMPLES + 20;
    localparam int QUIET_AFTER  = DECAY_SAMPLES + 64;
    localparam int RETRIG_WIN   = 8;
    // every part of the stimulus at its longest
    localparam int PLANNED_SAMPLES = 4 * (200 + 300) + (200 + 40 + 200 + 300)
                                   + RAND_STEPS * (400 + 300) + TAIL_SAMPLES;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + (SAMPLE_DIV * PLANNED_SAMPLES * 6) / 5;

    logic                       clk;
    logic                       reset;
    logic                       audio_clk_en = 1'b0;
    logic                       walk_en;
    logic signed [SAMPLE_W-1:0] out;
    int                         out_i;

    int seed       = 65121;
    int div_cnt    = 0;
    int sample_cnt = 0;
    int cycle_cnt  = 0;

    // stimulus history, updated once per audio sample
    logic walk_seen;
    logic walk_prev;
    logic had_step;
    logic saw_pos;
    logic saw_neg;
    logic retrig_nz;
    int   hold_len;
    int   low_len;
    int   retrig_cnt;
    int   hold_checks    = 0;
    int   release_checks = 0;
    int   retrig_checks  = 0;

    int   out_prev;
    logic en_prev;

    int quiet_errs   = 0;
    int stable_errs  = 0;
    int bound_errs   = 0;
    int hold_errs    = 0;
    int release_errs = 0;
    int retrig_errs  = 0;
    int reach_errs   = 0;

    assign out_i = int'(out);

    dk_walk u_dut (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en),
        .walk_en      (walk_en),
        .out          (out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one sample strobe in every SAMPLE_DIV clocks
    always @(negedge clk) begin
        if (div_cnt == SAMPLE_DIV - 1) begin
            div_cnt      <= 0;
            audio_clk_en <= 1'b1;
        end else begin
            div_cnt      <= div_cnt + 1;
            audio_clk_en <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (audio_clk_en) begin
            sample_cnt <= sample_cnt + 1;
        end
        out_prev <= out_i;
        en_prev  <= audio_clk_en;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus history for the window checks
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            walk_seen  <= 1'b0;
            walk_prev  <= 1'b0;
            had_step   <= 1'b0;
            saw_pos    <= 1'b0;
            saw_neg    <= 1'b0;
            retrig_nz  <= 1'b0;
            hold_len   <= 0;
            low_len    <= 0;
            retrig_cnt <= 0;
        end else if (audio_clk_en) begin
            walk_prev <= walk_en;
            if (retrig_cnt != 0) begin
                retrig_cnt <= (retrig_cnt == RETRIG_WIN) ? 0 : retrig_cnt + 1;
                retrig_nz  <= retrig_nz || (out_i != 0);
                if (retrig_cnt == RETRIG_WIN) begin
                    retrig_checks <= retrig_checks + 1;
                end
            end
            if (walk_en) begin
                walk_seen <= 1'b1;
                low_len   <= 0;
                if (!walk_prev) begin
                    hold_len <= 1;
                    saw_pos  <= out_i > 0;
                    saw_neg  <= out_i < 0;
                    // a rise before the decay has run out is a retrigger
                    if (had_step && low_len < DECAY_SAMPLES) begin
                        retrig_cnt <= 1;
                        retrig_nz  <= 1'b0;
                    end
                end else begin
                    hold_len <= hold_len + 1;
                    saw_pos  <= saw_pos || (out_i > 0);
                    saw_neg  <= saw_neg || (out_i < 0);
                end
            end else begin
                low_len <= low_len + 1;
                if (walk_prev) begin
                    had_step <= 1'b1;
                    if (hold_len > HOLD_MIN) begin
                        hold_checks <= hold_checks + 1;
                    end
                end
                if (had_step && low_len == QUIET_AFTER) begin
                    release_checks <= release_checks + 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // checks on out
    //////////////////////////////////////////////////

    quiet_before_walk: assert property (@(posedge clk) disable iff (reset)
        !walk_seen |-> out_i == 0)
    else begin
        quiet_errs++;
        $display("ERR at %0t: out = %0d, expected %0d", $time, $sampled(out_i), 0);
    end

    stable_between_strobes: assert property (@(posedge clk) disable iff (reset)
        !en_prev |-> out_i == out_prev)
    else begin
        stable_errs++;
        $display("ERR at %0t: out = %0d, expected %0d", $time, $sampled(out_i),
                 $sampled(out_prev));
    end

    peak_bound: assert property (@(posedge clk) disable iff (reset)
        out_i <= PEAK && out_i >= -PEAK)
    else begin
        bound_errs++;
        $display("ERR at %0t: out = %0d, expected magnitude at most %0d", $time,
                 $sampled(out_i), PEAK);
    end

    swing_in_hold: assert property (@(posedge clk) disable iff (reset)
        (audio_clk_en && !walk_en && walk_prev && hold_len > HOLD_MIN) |-> (saw_pos && saw_neg))
    else begin
        hold_errs++;
        $display("at %0t a hold of %0d samples did not swing out to both signs", $time,
                 $sampled(hold_len));
    end

    silent_after_release: assert property (@(posedge clk) disable iff (reset)
        (audio_clk_en && !walk_en && low_len >= QUIET_AFTER) |-> out_i == 0)
    else begin
        release_errs++;
        $display("ERR at %0t: out = %0d, expected %0d", $time, $sampled(out_i), 0);
    end

    sound_after_retrigger: assert property (@(posedge clk) disable iff (reset)
        (audio_clk_en && retrig_cnt == RETRIG_WIN) |-> (retrig_nz || out_i != 0))
    else begin
        retrig_errs++;
        $display("at %0t out stayed silent for %0d samples after a retrigger", $time,
                 RETRIG_WIN);
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic wait_samples(input int n);
        int target;
        target = sample_cnt + n;
        while (sample_cnt < target) begin
            @(negedge clk);
        end
    endtask

    task automatic play_step(input int high_n, input int low_n);
        walk_en = 1'b1;
        wait_samples(high_n);
        walk_en = 1'b0;
        wait_samples(low_n);
    endtask

    initial begin
        int high_n;
        int total_errs;
        reset   = 1'b1;
        walk_en = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        repeat (4) play_step(200, 300);

        // walk again 40 samples into the decay
        play_step(200, 40);
        play_step(200, 300);

        repeat (RAND_STEPS) begin
            high_n = 80 + int'($unsigned($random(seed)) % 321);
            play_step(high_n, 300);
        end

        wait_samples(TAIL_SAMPLES);

        if (hold_checks == 0 || release_checks == 0 || retrig_checks == 0) begin
            reach_errs++;
            $display("the stimulus did not reach every check: hold %0d, release %0d, retrigger %0d",
                     hold_checks, release_checks, retrig_checks);
        end
        total_errs = quiet_errs + stable_errs + bound_errs + hold_errs + release_errs
                   + retrig_errs + reach_errs;
        $write("errors %0d: quiet %0d, stable %0d, bound %0d, ", total_errs, quiet_errs,
               stable_errs, bound_errs);
        $display("hold %0d, release %0d, retrigger %0d, reach %0d", hold_errs, release_errs,
                 retrig_errs, reach_errs);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dk_walk.f
design/walk_sound_pkg.sv
design/walk_sequencer.sv
design/walk_phase_timer.sv
design/walk_oscillator.sv
design/walk_vca_filter.sv
design/dk_walk.sv
testbench/tb_dk_walk.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dk_walk
FILELIST  ?= dk_walk.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and look for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
